// ==== logic/mips_pkg.sv ====
/*
 * Shared widths, opcodes and control types for the five-stage core.
 * Only add, sub, and, or, slt, addi, lw and sw are decoded.
 */
package mips_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int dmem_words = 256;
    localparam int dmem_idx_w = $clog2(dmem_words);

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // funct field of R-type, instr[5:0]
    localparam logic [5:0] funct_add = 6'h20;
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2a;

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_slt = 3'd4
    } alu_op_t;

    // all-zero word is a no-op
    typedef struct packed {
        logic reg_write;
        logic reg_dst_rd;   // rd for R-type, rt otherwise
        logic alu_src_imm;
        logic mem_read;
        logic mem_write;
        logic mem_to_reg;
    } ctrl_t;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_t;

endpackage

// ==== logic/reg_file.sv ====
/*
 * 32 x 32 register file, r0 reads zero. Same-cycle write shows on the reads.
 */
`timescale 1ns/1ns

module reg_file (
    input  logic                SYS_clk,
    input  mips_pkg::reg_addr_t rd_addr_a,
    input  mips_pkg::reg_addr_t rd_addr_b,
    output mips_pkg::word_t     rd_data_a,
    output mips_pkg::word_t     rd_data_b,
    input  logic                wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data
);
    import mips_pkg::*;

    word_t regs [2**reg_addr_w];

    always_ff @(posedge SYS_clk)
    begin
        if (wr_en && wr_addr != '0)
            regs[wr_addr] <= wr_data;
    end

    // write-through so decode sees the writeback value
    assign rd_data_a = (rd_addr_a == '0)                 ? '0      :
                       (wr_en && wr_addr == rd_addr_a)   ? wr_data :
                                                           regs[rd_addr_a];

    assign rd_data_b = (rd_addr_b == '0)                 ? '0      :
                       (wr_en && wr_addr == rd_addr_b)   ? wr_data :
                                                           regs[rd_addr_b];

endmodule

// ==== logic/decode_stage.sv ====
/*
 * IF/ID register plus decode. Unknown opcodes decode to a no-op.
 */
`timescale 1ns/1ns

module decode_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::word_t     instr_data,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_reg,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::ctrl_t     d_ctrl,
    output mips_pkg::word_t     d_rs_val,
    output mips_pkg::word_t     d_rt_val,
    output mips_pkg::word_t     d_imm,
    output mips_pkg::reg_addr_t d_rs,
    output mips_pkg::reg_addr_t d_rt,
    output mips_pkg::reg_addr_t d_dest,
    output logic [5:0]          d_funct
);
    import mips_pkg::*;

    word_t ifid_instr;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ifid_instr <= '0;   // decodes as no-op
        else
            ifid_instr <= instr_data;
    end

    always_comb
    begin
        d_ctrl = '0;
        case (ifid_instr[31:26])
            op_rtype: d_ctrl = '{reg_write: 1'b1, reg_dst_rd: 1'b1, default: 1'b0};
            op_addi:  d_ctrl = '{reg_write: 1'b1, alu_src_imm: 1'b1, default: 1'b0};
            op_lw:
            begin
                d_ctrl = '{reg_write: 1'b1, alu_src_imm: 1'b1, mem_read: 1'b1,
                           mem_to_reg: 1'b1, default: 1'b0};
            end
            op_sw:    d_ctrl = '{alu_src_imm: 1'b1, mem_write: 1'b1, default: 1'b0};
            default:  d_ctrl = '0;
        endcase
    end

    assign d_rs    = ifid_instr[25:21];
    assign d_rt    = ifid_instr[20:16];
    assign d_funct = ifid_instr[5:0];
    assign d_imm   = {{(xlen-16){ifid_instr[15]}}, ifid_instr[15:0]};
    assign d_dest  = d_ctrl.reg_dst_rd ? ifid_instr[15:11] : ifid_instr[20:16];

    reg_file i_reg_file (
        .SYS_clk(SYS_clk),
        .rd_addr_a(d_rs), .rd_addr_b(d_rt),
        .rd_data_a(d_rs_val), .rd_data_b(d_rt_val),
        .wr_en(wb_en), .wr_addr(wb_reg), .wr_data(wb_data)
    );

endmodule

// ==== logic/forward_unit.sv ====
/*
 * Operand bypass select. Memory stage wins over writeback; r0 never forwards.
 */
`timescale 1ns/1ns

module forward_unit (
    input  mips_pkg::reg_addr_t ex_rs,
    input  mips_pkg::reg_addr_t ex_rt,
    input  logic                mem_reg_write,
    input  mips_pkg::reg_addr_t mem_dest,
    input  logic                wb_en,
    input  mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::fwd_sel_t  fwd_a,
    output mips_pkg::fwd_sel_t  fwd_b
);
    import mips_pkg::*;

    logic mem_ok;
    logic wb_ok;

    // producer must write a real register
    assign mem_ok = mem_reg_write && (mem_dest != '0);
    assign wb_ok  = wb_en && (wb_reg != '0);

    function automatic fwd_sel_t pick(input reg_addr_t src);
        if (mem_ok && mem_dest == src)
            return fwd_mem;
        else if (wb_ok && wb_reg == src)
            return fwd_wb;
        else
            return fwd_none;
    endfunction

    always_comb
    begin
        fwd_a = pick(ex_rs);
        fwd_b = pick(ex_rt);
    end

endmodule

// ==== logic/execute_stage.sv ====
/*
 * ID/EX register, operand bypass and ALU. A load in the memory stage
 * forwards its address, not its data, so consumers must wait one slot.
 */
`timescale 1ns/1ns

module execute_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::ctrl_t     d_ctrl,
    input  mips_pkg::word_t     d_rs_val,
    input  mips_pkg::word_t     d_rt_val,
    input  mips_pkg::word_t     d_imm,
    input  mips_pkg::reg_addr_t d_rs,
    input  mips_pkg::reg_addr_t d_rt,
    input  mips_pkg::reg_addr_t d_dest,
    input  logic [5:0]          d_funct,
    input  mips_pkg::fwd_sel_t  fwd_a,
    input  mips_pkg::fwd_sel_t  fwd_b,
    input  mips_pkg::word_t     mem_alu,
    input  mips_pkg::word_t     wb_data,
    output mips_pkg::reg_addr_t ex_rs,
    output mips_pkg::reg_addr_t ex_rt,
    output mips_pkg::ctrl_t     ex_ctrl,
    output mips_pkg::word_t     ex_alu,
    output mips_pkg::word_t     ex_store,
    output mips_pkg::reg_addr_t ex_dest
);
    import mips_pkg::*;

    word_t      idex_rs_val, idex_rt_val, idex_imm;
    logic [5:0] idex_funct;
    word_t      op_a, op_b;
    alu_op_t    alu_op;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            ex_ctrl <= '0;
            ex_rs   <= '0;
            ex_rt   <= '0;
            ex_dest <= '0;
        end
        else
        begin
            ex_ctrl <= d_ctrl;
            ex_rs   <= d_rs;
            ex_rt   <= d_rt;
            ex_dest <= d_dest;
        end
        idex_rs_val <= d_rs_val;
        idex_rt_val <= d_rt_val;
        idex_imm    <= d_imm;
        idex_funct  <= d_funct;
    end

    assign op_a = (fwd_a == fwd_mem) ? mem_alu :
                  (fwd_a == fwd_wb)  ? wb_data : idex_rs_val;

    assign ex_store = (fwd_b == fwd_mem) ? mem_alu :
                      (fwd_b == fwd_wb)  ? wb_data : idex_rt_val;   // forwarded rt

    assign op_b = ex_ctrl.alu_src_imm ? idex_imm : ex_store;

    always_comb
    begin
        alu_op = alu_add;   // addi, lw, sw compute an address or sum
        if (ex_ctrl.reg_dst_rd)
        begin
            case (idex_funct)
                funct_sub: alu_op = alu_sub;
                funct_and: alu_op = alu_and;
                funct_or:  alu_op = alu_or;
                funct_slt: alu_op = alu_slt;
                default:   alu_op = alu_add;
            endcase
        end
    end

    always_comb
    begin
        case (alu_op)
            alu_sub: ex_alu = op_a - op_b;
            alu_and: ex_alu = op_a & op_b;
            alu_or:  ex_alu = op_a | op_b;
            alu_slt: ex_alu = ($signed(op_a) < $signed(op_b)) ? word_t'(1) : '0;
            default: ex_alu = op_a + op_b;
        endcase
    end

    // load-use on rs right behind a lw is not handled by the pipeline
    a_no_load_fwd: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        ex_ctrl.mem_read |=> fwd_a != fwd_mem);

endmodule

// ==== logic/memory_stage.sv ====
/*
 * EX/MEM register and word-addressed data memory, aligned words only.
 * Addresses wrap at dmem_words.
 */
`timescale 1ns/1ns

module memory_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::ctrl_t     ex_ctrl,
    input  mips_pkg::word_t     ex_alu,
    input  mips_pkg::word_t     ex_store,
    input  mips_pkg::reg_addr_t ex_dest,
    output mips_pkg::ctrl_t     mem_ctrl,
    output mips_pkg::word_t     mem_alu,
    output mips_pkg::word_t     mem_rdata,
    output mips_pkg::reg_addr_t mem_dest
);
    import mips_pkg::*;

    word_t                 mem_store;
    word_t                 dmem [dmem_words];
    logic [dmem_idx_w-1:0] widx;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_ctrl <= '0;
            mem_dest <= '0;
        end
        else
        begin
            mem_ctrl <= ex_ctrl;
            mem_dest <= ex_dest;
        end
        mem_alu   <= ex_alu;
        mem_store <= ex_store;
    end

    assign widx = mem_alu[dmem_idx_w+1:2];   // byte address to word index

    always_ff @(posedge SYS_clk)
    begin
        if (mem_ctrl.mem_write)
            dmem[widx] <= mem_store;
    end

    assign mem_rdata = dmem[widx];   // async read

    a_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (mem_ctrl.mem_read || mem_ctrl.mem_write) |-> mem_alu[1:0] == 2'b00);

endmodule

// ==== logic/writeback_stage.sv ====
/*
 * MEM/WB register and result select. Writes to r0 are suppressed here.
 */
`timescale 1ns/1ns

module writeback_stage (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    input  mips_pkg::ctrl_t     mem_ctrl,
    input  mips_pkg::word_t     mem_alu,
    input  mips_pkg::word_t     mem_rdata,
    input  mips_pkg::reg_addr_t mem_dest,
    output logic                wb_en,
    output mips_pkg::reg_addr_t wb_reg,
    output mips_pkg::word_t     wb_data
);
    import mips_pkg::*;

    ctrl_t wb_ctrl;
    word_t wb_alu, wb_rdata;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_ctrl <= '0;
            wb_reg  <= '0;
        end
        else
        begin
            wb_ctrl <= mem_ctrl;
            wb_reg  <= mem_dest;
        end
        wb_alu   <= mem_alu;
        wb_rdata <= mem_rdata;
    end

    assign wb_data = wb_ctrl.mem_to_reg ? wb_rdata : wb_alu;  // load or ALU
    assign wb_en   = wb_ctrl.reg_write && (wb_reg != '0);

endmodule

// ==== logic/mips_core.sv ====
/*
 * Five-stage integer pipeline without branches and without hazard stall.
 * A lw result may be used from the second instruction after the load on.
 */
`timescale 1ns/1ns

module mips_core (
    input  logic                SYS_clk,
    input  logic                SYS_reset,
    output mips_pkg::word_t     instr_addr,
    input  mips_pkg::word_t     instr_data,
    output logic                retire_en,
    output mips_pkg::reg_addr_t retire_reg,
    output mips_pkg::word_t     retire_data
);
    import mips_pkg::*;

    word_t     pc;
    ctrl_t     d_ctrl, ex_ctrl, mem_ctrl;
    word_t     d_rs_val, d_rt_val, d_imm;
    reg_addr_t d_rs, d_rt, d_dest;
    logic [5:0] d_funct;
    reg_addr_t ex_rs, ex_rt, ex_dest, mem_dest, wb_reg;
    word_t     ex_alu, ex_store, mem_alu, mem_rdata, wb_data;
    fwd_sel_t  fwd_a, fwd_b;
    logic      wb_en;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc <= '0;
        else
            pc <= pc + word_t'(4);  // no branches, straight-line fetch
    end

    assign instr_addr = pc;

    decode_stage i_decode (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset), .instr_data(instr_data),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
        .d_ctrl(d_ctrl), .d_rs_val(d_rs_val), .d_rt_val(d_rt_val), .d_imm(d_imm),
        .d_rs(d_rs), .d_rt(d_rt), .d_dest(d_dest), .d_funct(d_funct)
    );

    execute_stage i_execute (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .d_ctrl(d_ctrl), .d_rs_val(d_rs_val), .d_rt_val(d_rt_val), .d_imm(d_imm),
        .d_rs(d_rs), .d_rt(d_rt), .d_dest(d_dest), .d_funct(d_funct),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .mem_alu(mem_alu), .wb_data(wb_data),
        .ex_rs(ex_rs), .ex_rt(ex_rt), .ex_ctrl(ex_ctrl), .ex_alu(ex_alu),
        .ex_store(ex_store), .ex_dest(ex_dest)
    );

    forward_unit i_forward (
        .ex_rs(ex_rs), .ex_rt(ex_rt),
        .mem_reg_write(mem_ctrl.reg_write), .mem_dest(mem_dest),
        .wb_en(wb_en), .wb_reg(wb_reg),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    memory_stage i_memory (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .ex_ctrl(ex_ctrl), .ex_alu(ex_alu), .ex_store(ex_store), .ex_dest(ex_dest),
        .mem_ctrl(mem_ctrl), .mem_alu(mem_alu), .mem_rdata(mem_rdata), .mem_dest(mem_dest)
    );

    writeback_stage i_writeback (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .mem_ctrl(mem_ctrl), .mem_alu(mem_alu), .mem_rdata(mem_rdata), .mem_dest(mem_dest),
        .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
    );

    // every register write is reported
    assign retire_en   = wb_en;
    assign retire_reg  = wb_reg;
    assign retire_data = wb_data;

endmodule

// ==== test/tb_program.svh ====
/*
 * Test program for the core: one instruction per fetch slot, plus the retire it causes.
 * A lw result is used no earlier than the second instruction after it. No branches.
 */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

typedef struct {
    word_t     instr;
    int        test;      // numbered behavior this step belongs to
    logic      retires;
    reg_addr_t rd;
    word_t     value;
} prog_entry_t;

prog_entry_t prog [$];

function automatic word_t r_type(input logic [5:0] funct, input int rd, input int rs,
                                 input int rt);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
endfunction

function automatic word_t i_type(input opcode_t op, input int rt, input int rs, input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

task automatic append_step(input word_t instr, input int test, input logic retires,
                           input int rd, input word_t value);
    prog_entry_t e;
    e.instr   = instr;
    e.test    = test;
    e.retires = retires;
    e.rd      = 5'(rd);
    e.value   = value;
    prog.push_back(e);
endtask

// columns: instruction, test, retires, register, expected value
task automatic load_program();
    append_step(i_type(op_addi, 1, 0, 5),              2, 1'b1, 1, 32'd5);
    append_step(i_type(op_addi, 2, 0, -3),             2, 1'b1, 2, 32'hffff_fffd);
    append_step(i_type(op_addi, 3, 0, 100),            2, 1'b1, 3, 32'd100);
    append_step(i_type(op_addi, 4, 1, -7),             2, 1'b1, 4, 32'hffff_fffe);
    append_step(r_type(funct_add, 5, 1, 2),            3, 1'b1, 5, 32'd2);
    append_step(r_type(funct_sub, 6, 1, 2),            3, 1'b1, 6, 32'd8);
    append_step(r_type(funct_and, 7, 1, 3),            3, 1'b1, 7, 32'd4);
    append_step(r_type(funct_or, 8, 1, 3),             3, 1'b1, 8, 32'd101);
    append_step(r_type(funct_slt, 9, 2, 1),            3, 1'b1, 9, 32'd1);
    append_step(r_type(funct_slt, 10, 1, 2),           3, 1'b1, 10, 32'd0);
    append_step(i_type(op_addi, 11, 0, 10),            4, 1'b1, 11, 32'd10);
    append_step(r_type(funct_add, 12, 11, 1),          4, 1'b1, 12, 32'd15);  // rs from mem
    append_step(r_type(funct_add, 13, 1, 12),          4, 1'b1, 13, 32'd20);  // rt from mem
    append_step(r_type(funct_sub, 14, 12, 1),          4, 1'b1, 14, 32'd10);  // rs from wb
    append_step(r_type(funct_sub, 15, 1, 13),          4, 1'b1, 15, 32'hffff_fff1);
    append_step(r_type(funct_add, 16, 14, 14),         4, 1'b1, 16, 32'd20);
    append_step(r_type(funct_add, 17, 16, 16),         4, 1'b1, 17, 32'd40);
    append_step(i_type(op_addi, 17, 17, 1),            4, 1'b1, 17, 32'd41);
    append_step(r_type(funct_add, 18, 17, 17),         4, 1'b1, 18, 32'd82);  // mem beats wb
    append_step(i_type(op_addi, 20, 0, 64),            5, 1'b1, 20, 32'd64);
    append_step(i_type(op_sw, 18, 20, 0),              5, 1'b0, 0, 32'd0);
    append_step(i_type(op_sw, 2, 20, 4),               5, 1'b0, 0, 32'd0);
    append_step(i_type(op_lw, 21, 20, 0),              5, 1'b1, 21, 32'd82);
    append_step(i_type(op_lw, 22, 20, 4),              5, 1'b1, 22, 32'hffff_fffd);
    append_step(r_type(funct_add, 23, 21, 1),          5, 1'b1, 23, 32'd87);
    append_step(r_type(funct_sub, 24, 22, 1),          5, 1'b1, 24, 32'hffff_fff8);
    append_step(i_type(op_addi, 0, 1, 9),              6, 1'b0, 0, 32'd0);
    append_step(r_type(funct_add, 0, 1, 1),            6, 1'b0, 0, 32'd0);
    append_step(r_type(funct_add, 25, 0, 1),           6, 1'b1, 25, 32'd5);
    append_step(r_type(funct_or, 26, 0, 0),            6, 1'b1, 26, 32'd0);
endtask

`endif

// ==== test/tb_mips_core.sv ====
/*
 * Testbench for mips_core. Fetch is modeled from a fixed table, one word per cycle.
 * Retires are checked at the falling edge against the cycle k+4 rule.
 */
`timescale 1ns/1ns

module tb_mips_core;
    import mips_pkg::*;

    localparam int reset_cycles = 10;
    localparam int num_tests    = 6;
    localparam int drain_cycles = 6;   // pipeline empties after the last fetch

    typedef struct {
        int        cycle;
        reg_addr_t rd;
        word_t     value;
        int        test;
    } retire_rec_t;

    logic      SYS_clk;
    logic      SYS_reset;
    word_t     instr_addr;
    word_t     instr_data;
    logic      retire_en;
    reg_addr_t retire_reg;
    word_t     retire_data;

    `include "tb_program.svh"

    retire_rec_t expected [$];
    int          test_end [1:num_tests];
    int          test_errors [1:num_tests];
    string       test_name [1:num_tests];
    int          cyc;          // cycles since reset release
    int          run_cycles;
    int          limit;
    int          watch_cycles;
    int          tests_done;
    int          tests_failed;
    int          error_total;

    mips_core i_mips_core (
        .SYS_clk(SYS_clk), .SYS_reset(SYS_reset),
        .instr_addr(instr_addr), .instr_data(instr_data),
        .retire_en(retire_en), .retire_reg(retire_reg), .retire_data(retire_data)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #4 SYS_clk = ~SYS_clk;
    end

    function automatic word_t fetch_word(input int idx);
        return (idx < prog.size()) ? prog[idx].instr : '0;   // nop past the end
    endfunction

    task automatic count_error(input int t);
        test_errors[t]++;
        error_total++;
    endtask

    task automatic build_expected();
        retire_rec_t rec;
        foreach (prog[i])
        begin
            if (prog[i].retires)
            begin
                rec.cycle = i + 4;
                rec.rd    = prog[i].rd;
                rec.value = prog[i].value;
                rec.test  = prog[i].test;
                expected.push_back(rec);
            end
            test_end[prog[i].test] = i + 4;
        end
    endtask

    task automatic report_test(input int t);
        if (test_errors[t] != 0)
            tests_failed++;
        $display("test %0d %s: %s (%0d errors)", t, test_name[t],
                 (test_errors[t] == 0) ? "ok" : "failed", test_errors[t]);
        tests_done++;
    endtask

    task automatic check_cycle();
        retire_rec_t rec;
        int          owner;
        owner = (cyc >= 4 && cyc - 4 < prog.size()) ? prog[cyc-4].test : 1;
        assert (instr_addr === word_t'(4 * cyc))
        else
        begin
            $display("CHECK FAILED t=%0t: instr_addr %h, expected %h", $time, instr_addr,
                     word_t'(4 * cyc));
            count_error(1);
        end
        if (cyc < 4)
        begin
            assert (retire_en === 1'b0)
            else
            begin
                $display("CHECK FAILED t=%0t: retire_en high in cycle %0d after reset",
                         $time, cyc);
                count_error(1);
            end
        end
        if (expected.size() > 0 && expected[0].cycle == cyc)
        begin
            rec = expected.pop_front();
            assert (retire_en === 1'b1 && retire_reg === rec.rd && retire_data === rec.value)
            else
            begin
                $display("CHECK FAILED t=%0t: expected r%0d = %h, got en %b r%0d = %h",
                         $time, rec.rd, rec.value, retire_en, retire_reg, retire_data);
                count_error(rec.test);
            end
        end
        else
        begin
            assert (retire_en === 1'b0)
            else
            begin
                $display("CHECK FAILED t=%0t: unexpected retire r%0d = %h", $time,
                         retire_reg, retire_data);
                count_error(owner);
            end
        end
        for (int t = 1; t <= num_tests; t++)
        begin
            if (test_end[t] == cyc)
                report_test(t);
        end
    endtask

    always @(negedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            assert (retire_en === 1'b0)
            else
            begin
                $display("CHECK FAILED t=%0t: retire_en high during reset", $time);
                count_error(1);
            end
        end
        else
        begin
            check_cycle();
            cyc++;
        end
    end

    // run limit
    always @(posedge SYS_clk)
    begin
        watch_cycles++;
        if (watch_cycles > limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        SYS_reset    = 1'b1;
        instr_data   = '0;
        cyc          = 0;
        watch_cycles = 0;
        tests_done   = 0;
        tests_failed = 0;
        error_total  = 0;
        test_name    = '{"reset", "addi", "r-type", "forwarding", "memory", "register zero"};
        for (int t = 1; t <= num_tests; t++)
        begin
            test_errors[t] = 0;
            test_end[t]    = -1;
        end
        load_program();
        build_expected();
        run_cycles  = prog.size() + drain_cycles;
        test_end[1] = run_cycles - 1;   // address checks span the whole run
        limit       = reset_cycles + prog.size() + 20;

        repeat (reset_cycles) @(posedge SYS_clk);
        SYS_reset  <= 1'b0;
        instr_data <= fetch_word(0);
        for (int i = 1; i < run_cycles; i++)
        begin
            @(posedge SYS_clk);
            instr_data <= fetch_word(i);
        end
        wait (tests_done == num_tests);

        $display("tests passed %0d, failed %0d, checks failed %0d",
                 num_tests - tests_failed, tests_failed, error_total);
        if (error_total == 0 && tests_failed == 0 && expected.size() == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== mips_core.f ====
+incdir+test
logic/mips_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/mips_core.sv
test/tb_mips_core.sv

// ==== Makefile ====
# Verilator build and run for the mips_core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= mips_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
